// File: project.f
src/idli_ex_pkg.sv
src/idli_ex_seq.sv
src/idli_ex_rf.sv
src/idli_ex_alu.sv
src/idli_ex_shift.sv
src/idli_ex_wb.sv
src/idli_ex_core.sv
bench/idli_ex_tb.sv

// File: bench/idli_ex_patterns.hex
// Columns: unit op cond dst lhs rhs rhs_imm imm, then expected wr_vld wr_data pred.
// Units ALU=0 SHIFT=1 CMP=2; cond ALWAYS=0 IF_P=1 IF_NOT_P=2; data is don't-care when wr_vld=0.
0 0 0 1 0 0 1 0FFF 1 0FFF 0
0 0 0 2 1 0 1 0001 1 1000 0
0 1 0 3 0 2 0 0000 1 F000 0
0 0 0 4 3 1 0 0000 1 FFFF 0
0 0 0 5 4 0 1 0001 1 0000 0
0 2 0 6 4 0 1 8888 1 8888 0
0 3 0 7 0 0 1 1111 1 1111 0
0 4 0 1 6 7 0 0000 1 9999 0
0 1 0 2 7 0 1 0002 1 110F 0
0 2 0 3 1 2 0 0000 1 1109 0
0 3 0 5 6 7 0 0000 1 9999 0
0 4 0 4 2 0 1 FFFF 1 EEF0 0
// Shifts across slice boundaries
1 0 0 1 6 0 0 0000 1 1110 0
1 1 0 2 6 0 0 0000 1 4444 0
1 2 0 3 6 0 0 0000 1 C444 0
1 3 0 4 6 0 0 0000 1 1111 0
1 1 0 5 7 0 0 0000 1 0888 0
0 3 0 1 0 0 1 8001 1 8001 0
1 3 0 2 1 0 0 0000 1 0003 0
1 2 0 3 1 0 0 0000 1 C000 0
1 1 0 4 1 0 0 0000 1 4000 0
1 0 0 5 1 0 0 0000 1 0002 0
// Compares write only P
2 0 0 0 6 6 0 0000 0 0000 1
2 1 0 0 6 0 1 8888 0 0000 0
2 2 0 0 6 7 0 0000 0 0000 1
2 3 0 0 6 7 0 0000 0 0000 0
2 4 0 0 7 6 0 0000 0 0000 1
2 5 0 0 7 6 0 0000 0 0000 0
2 3 0 0 0 0 1 FFFF 0 0000 1
2 2 0 0 0 0 1 FFFF 0 0000 0
2 5 0 0 4 0 1 4000 0 0000 1
2 4 0 0 3 4 0 0000 0 0000 0
2 0 0 0 0 0 1 0000 0 0000 1
2 1 0 0 0 0 0 0000 0 0000 0
// Predicated execution
0 0 1 1 0 0 1 1234 0 0000 0
0 0 2 1 0 0 1 1234 1 1234 0
2 0 1 0 0 0 0 0000 0 0000 0
2 0 0 0 0 0 0 0000 0 0000 1
0 1 2 2 1 0 1 0001 0 0000 1
0 1 1 2 1 0 1 0234 1 1000 1
2 0 2 0 0 0 1 0001 0 0000 1
2 3 1 0 0 0 1 0000 0 0000 0
1 0 1 3 2 0 0 0000 0 0000 0
1 0 2 3 2 0 0 0000 1 2000 0
// R0 stays zero
0 0 0 0 7 0 1 0001 1 1112 0
0 0 0 4 0 0 0 0000 1 0000 0
0 4 0 6 3 0 0 0000 1 2000 0
0 0 0 7 6 3 0 0000 1 4000 0

// File: bench/idli_ex_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Testbench for the nibble-serial execution core.
// Instructions and their expected results are replayed from a pattern file.
// Each result is checked on the falling edge after its fixed four-cycle latency.
module idli_ex_tb;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 16;
  localparam int NUM_PAT    = 48;
  localparam int NUM_FIELDS = 11;

  // Each pattern takes at most MIN_GAP+3 cycles, so this leaves a margin.
  localparam int WATCHDOG_CYCLES = RST_CYCLES + NUM_PAT * (idli_ex_pkg::MIN_GAP + 4) + 40;

  // Column positions within one pattern line.
  localparam int F_UNIT = 0;
  localparam int F_OP   = 1;
  localparam int F_COND = 2;
  localparam int F_DST  = 3;
  localparam int F_LHS  = 4;
  localparam int F_RHS  = 5;
  localparam int F_ISEL = 6;
  localparam int F_IMM  = 7;
  localparam int F_WR   = 8;
  localparam int F_DATA = 9;
  localparam int F_PRED = 10;

  logic                gck;
  logic                rst_n;
  idli_ex_pkg::instr_t instr;
  logic                instr_vld;

  logic                wr_vld;
  idli_ex_pkg::reg_t   wr_reg;
  idli_ex_pkg::word_t  wr_data;
  logic                pred;

  // All pattern columns, one 16-bit token each, line after line.
  logic [15:0] pat_mem [0:NUM_PAT*NUM_FIELDS-1];

  // State of the generator for the extra idle cycles between strobes.
  logic [31:0] lcg_state;

  idli_ex_core idli_ex_core_i (
    .i_ex_gck       (gck),
    .i_ex_rst_n     (rst_n),
    .i_ex_instr     (instr),
    .i_ex_instr_vld (instr_vld),
    .o_ex_wr_vld    (wr_vld),
    .o_ex_wr_reg    (wr_reg),
    .o_ex_wr_data   (wr_data),
    .o_ex_pred      (pred)
  );

  initial begin
    gck = 1'b0;
    forever #(CLK_PERIOD / 2) gck = ~gck;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Assembles the instruction of one pattern and raises the strobe.
  task automatic drive_instr(input int idx);
    int                  base;
    idli_ex_pkg::instr_t ins;
    base        = idx * NUM_FIELDS;
    ins.unit    = idli_ex_pkg::unit_t'(pat_mem[base+F_UNIT][1:0]);
    ins.op      = pat_mem[base+F_OP][2:0];
    ins.cond    = idli_ex_pkg::cond_t'(pat_mem[base+F_COND][1:0]);
    ins.dst     = pat_mem[base+F_DST][2:0];
    ins.lhs     = pat_mem[base+F_LHS][2:0];
    ins.rhs     = pat_mem[base+F_RHS][2:0];
    ins.rhs_imm = pat_mem[base+F_ISEL][0];
    ins.imm     = pat_mem[base+F_IMM];
    instr       = ins;
    instr_vld   = 1'b1;
  endtask

  // Compares the outputs in the cycle after the fourth slice edge.
  task automatic check_result(input int idx);
    int base;
    base = idx * NUM_FIELDS;
    check_value($sformatf("pattern %0d write strobe", idx), pat_mem[base+F_WR], wr_vld);
    // Data and index only mean something when the write strobe is up.
    if (pat_mem[base+F_WR][0]) begin
      check_value($sformatf("pattern %0d write data", idx), pat_mem[base+F_DATA], wr_data);
      check_value($sformatf("pattern %0d write register", idx), pat_mem[base+F_DST],
                  wr_reg);
    end
    check_value($sformatf("pattern %0d predicate", idx), pat_mem[base+F_PRED], pred);
  endtask

  initial begin
    int extra;
    instr     = '0;
    instr_vld = 1'b0;
    rst_n     = 1'b0;
    lcg_state = 32'hcb5a;

    $readmemh("bench/idli_ex_patterns.hex", pat_mem);
    if ($isunknown(pat_mem[NUM_PAT*NUM_FIELDS-1])) begin
      $display("Pattern file bench/idli_ex_patterns.hex is missing or incomplete");
      $display("STATUS: FAIL");
      $fatal(1, "Cannot run without patterns");
    end

    repeat (RST_CYCLES) @(posedge gck);
    @(negedge gck);
    rst_n = 1'b1;

    // Nothing is written and P is clear straight after reset.
    @(negedge gck);
    check_value("reset write strobe", 32'd0, wr_vld);
    check_value("reset predicate", 32'd0, pred);

    for (int i = 0; i < NUM_PAT; i++) begin
      drive_instr(i);
      @(negedge gck);
      instr_vld = 1'b0;

      // No write may show up before the result is due.
      for (int c = 1; c <= 4; c++) begin
        check_value($sformatf("pattern %0d early write strobe", i), 32'd0, wr_vld);
        @(negedge gck);
      end
      check_result(i);

      // Spacing is MIN_GAP plus zero to three idle cycles.
      lcg_state = lcg_next(lcg_state);
      extra     = int'(lcg_state[17:16]);
      repeat (extra) begin
        @(negedge gck);
        check_value($sformatf("pattern %0d idle write strobe", i), 32'd0, wr_vld);
      end
    end

    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before all patterns ran", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

`default_nettype wire

// File: src/idli_ex_core.sv
`timescale 1ns/1ps
`default_nettype none

// Execution core top level. Sequencer, register file, ALU, shifter and
// writeback are connected here.
module idli_ex_core (
  input  var logic                 i_ex_gck,
  input  var logic                 i_ex_rst_n,

  input  var idli_ex_pkg::instr_t  i_ex_instr,
  input  var logic                 i_ex_instr_vld,

  output var logic                 o_ex_wr_vld,
  output var idli_ex_pkg::reg_t    o_ex_wr_reg,
  output var idli_ex_pkg::word_t   o_ex_wr_data,
  output var logic                 o_ex_pred
);

  // Decoded controls, slice position and busy level from the sequencer.
  idli_ex_pkg::ctrl_t  ctrl;
  idli_ex_pkg::ctr_t   ctr;
  logic                busy;

  // Operand indices and slices.
  idli_ex_pkg::reg_t   lhs_reg;
  idli_ex_pkg::reg_t   rhs_reg;
  idli_ex_pkg::slice_t lhs_slice;
  logic                lhs_next;
  logic                lhs_prev;
  idli_ex_pkg::slice_t rhs_reg_slice;
  idli_ex_pkg::slice_t rhs_slice;

  // Result slices and flags.
  idli_ex_pkg::slice_t alu_slice;
  idli_ex_pkg::flags_t alu_flags;
  idli_ex_pkg::slice_t shift_slice;

  idli_ex_seq seq_u (
    .i_seq_gck           (i_ex_gck),
    .i_seq_rst_n         (i_ex_rst_n),
    .i_seq_instr         (i_ex_instr),
    .i_seq_instr_vld     (i_ex_instr_vld),
    .i_seq_rhs_reg_slice (rhs_reg_slice),
    .o_seq_ctrl          (ctrl),
    .o_seq_ctr           (ctr),
    .o_seq_busy          (busy),
    .o_seq_lhs           (lhs_reg),
    .o_seq_rhs           (rhs_reg),
    .o_seq_rhs_slice     (rhs_slice)
  );

  // The register file is written from the writeback outputs, which are also
  // the core outputs.
  idli_ex_rf rf_u (
    .i_rf_gck       (i_ex_gck),
    .i_rf_ctr       (ctr),
    .i_rf_lhs       (lhs_reg),
    .i_rf_rhs       (rhs_reg),
    .i_rf_wr_en     (o_ex_wr_vld),
    .i_rf_wr_reg    (o_ex_wr_reg),
    .i_rf_wr_data   (o_ex_wr_data),
    .o_rf_lhs_slice (lhs_slice),
    .o_rf_lhs_next  (lhs_next),
    .o_rf_lhs_prev  (lhs_prev),
    .o_rf_rhs_slice (rhs_reg_slice)
  );

  idli_ex_alu alu_u (
    .i_alu_gck   (i_ex_gck),
    .i_alu_ctr   (ctr),
    .i_alu_busy  (busy),
    .i_alu_ctrl  (ctrl),
    .i_alu_lhs   (lhs_slice),
    .i_alu_rhs   (rhs_slice),
    .o_alu_slice (alu_slice),
    .o_alu_flags (alu_flags)
  );

  idli_ex_shift shift_u (
    .i_shift_ctr   (ctr),
    .i_shift_op    (ctrl.shift_op),
    .i_shift_in    (lhs_slice),
    .i_shift_next  (lhs_next),
    .i_shift_prev  (lhs_prev),
    .o_shift_slice (shift_slice)
  );

  idli_ex_wb wb_u (
    .i_wb_gck         (i_ex_gck),
    .i_wb_rst_n       (i_ex_rst_n),
    .i_wb_ctrl        (ctrl),
    .i_wb_ctr         (ctr),
    .i_wb_busy        (busy),
    .i_wb_alu_slice   (alu_slice),
    .i_wb_shift_slice (shift_slice),
    .i_wb_flags       (alu_flags),
    .o_wb_wr_en       (o_ex_wr_vld),
    .o_wb_wr_reg      (o_ex_wr_reg),
    .o_wb_wr_data     (o_ex_wr_data),
    .o_wb_pred        (o_ex_pred)
  );

endmodule

`default_nettype wire

// File: src/idli_ex_wb.sv
`timescale 1ns/1ps
`default_nettype none

// Writeback. Builds the result word from the slices, holds the predicate and
// decides on the last slice whether the instruction takes effect.
module idli_ex_wb (
  input  var logic                 i_wb_gck,
  input  var logic                 i_wb_rst_n,

  input  var idli_ex_pkg::ctrl_t   i_wb_ctrl,
  input  var idli_ex_pkg::ctr_t    i_wb_ctr,
  input  var logic                 i_wb_busy,

  input  var idli_ex_pkg::slice_t  i_wb_alu_slice,
  input  var idli_ex_pkg::slice_t  i_wb_shift_slice,
  input  var idli_ex_pkg::flags_t  i_wb_flags,

  output var logic                 o_wb_wr_en,
  output var idli_ex_pkg::reg_t    o_wb_wr_reg,
  output var idli_ex_pkg::word_t   o_wb_wr_data,
  output var logic                 o_wb_pred
);

  // Last slice of a running instruction, and whether it is skipped.
  logic last;
  logic skip;

  // Predicate state and the value a compare would write.
  logic pred_q;
  logic pred_d;

  // Result slice from the selected unit and the word it fills.
  idli_ex_pkg::slice_t res_slice;
  idli_ex_pkg::word_t  res_q;

  logic                wr_en_q;
  idli_ex_pkg::reg_t   wr_reg_q;

  always_comb last = i_wb_busy && (&i_wb_ctr);

  always_comb begin
    unique case (i_wb_ctrl.cond)
      idli_ex_pkg::COND_IF_P:     skip = !pred_q;
      idli_ex_pkg::COND_IF_NOT_P: skip = pred_q;
      default:                    skip = 1'b0;
    endcase
  end

  always_comb begin
    unique case (i_wb_ctrl.cmp_op)
      idli_ex_pkg::CMP_EQ:  pred_d = i_wb_flags.z;
      idli_ex_pkg::CMP_LT:  pred_d = i_wb_flags.n != i_wb_flags.v;
      idli_ex_pkg::CMP_LTU: pred_d = !i_wb_flags.c;
      idli_ex_pkg::CMP_GE:  pred_d = i_wb_flags.n == i_wb_flags.v;
      idli_ex_pkg::CMP_GEU: pred_d = i_wb_flags.c;
      default:              pred_d = !i_wb_flags.z;
    endcase
  end

  always_comb res_slice = (i_wb_ctrl.unit == idli_ex_pkg::UNIT_SHIFT) ? i_wb_shift_slice
                                                                      : i_wb_alu_slice;

  // Slices enter at the top, so slice 0 ends up at the bottom after four.
  always_ff @(posedge i_wb_gck) begin
    if (i_wb_busy) begin
      res_q <= {res_slice, res_q[idli_ex_pkg::WORD_W-1:idli_ex_pkg::SLICE_W]};
    end
    if (last) begin
      wr_reg_q <= i_wb_ctrl.dst;
    end
  end

  // Compares only update P; other units write a register for one cycle.
  always_ff @(posedge i_wb_gck, negedge i_wb_rst_n) begin
    if (!i_wb_rst_n) begin
      pred_q  <= 1'b0;
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= last && !skip && i_wb_ctrl.unit != idli_ex_pkg::UNIT_CMP;
      if (last && !skip && i_wb_ctrl.unit == idli_ex_pkg::UNIT_CMP) begin
        pred_q <= pred_d;
      end
    end
  end

  always_comb o_wb_wr_en   = wr_en_q;
  always_comb o_wb_wr_reg  = wr_reg_q;
  always_comb o_wb_wr_data = res_q;
  always_comb o_wb_pred    = pred_q;

  // One write per instruction, and instructions are spaced apart.
  a_wr_single: assert property (@(posedge i_wb_gck) disable iff (!i_wb_rst_n)
    o_wb_wr_en |=> !o_wb_wr_en);

endmodule

`default_nettype wire

// File: src/idli_ex_shift.sv
`timescale 1ns/1ps
`default_nettype none

// Serial one-bit shifter. Each slice borrows one bit from a neighbouring
// slice of the same word.
module idli_ex_shift (
  input  var idli_ex_pkg::ctr_t        i_shift_ctr,
  input  var idli_ex_pkg::shift_op_t   i_shift_op,

  input  var idli_ex_pkg::slice_t      i_shift_in,
  input  var logic                     i_shift_next,
  input  var logic                     i_shift_prev,

  output var idli_ex_pkg::slice_t      o_shift_slice
);

  // Bit shifted in at the bottom for left shifts, or at the top for right.
  logic fill;

  always_comb begin
    unique case (i_shift_op)
      // SHL brings in 0 at the bottom of the word. Elsewhere the top bit of
      // the slice below moves up.
      idli_ex_pkg::SHIFT_SHL: fill = (i_shift_ctr == '0) ? 1'b0 : i_shift_prev;

      // The previous bit at slice 0 is already bit 15.
      idli_ex_pkg::SHIFT_ROL: fill = i_shift_prev;

      // Logical right shift puts 0 into bit 15.
      idli_ex_pkg::SHIFT_SRL: fill = (&i_shift_ctr) ? 1'b0 : i_shift_next;

      // Arithmetic right shift keeps the sign.
      default: fill = (&i_shift_ctr) ? i_shift_in[idli_ex_pkg::SLICE_W-1] : i_shift_next;
    endcase
  end

  always_comb begin
    if (i_shift_op == idli_ex_pkg::SHIFT_SHL || i_shift_op == idli_ex_pkg::SHIFT_ROL) begin
      o_shift_slice = {i_shift_in[idli_ex_pkg::SLICE_W-2:0], fill};
    end else begin
      o_shift_slice = {fill, i_shift_in[idli_ex_pkg::SLICE_W-1:1]};
    end
  end

endmodule

`default_nettype wire

// File: src/idli_ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

// Serial ALU. One slice per cycle, with the carry held between slices.
module idli_ex_alu (
  input  var logic                 i_alu_gck,

  input  var idli_ex_pkg::ctr_t    i_alu_ctr,
  input  var logic                 i_alu_busy,
  input  var idli_ex_pkg::ctrl_t   i_alu_ctrl,

  input  var idli_ex_pkg::slice_t  i_alu_lhs,
  input  var idli_ex_pkg::slice_t  i_alu_rhs,

  output var idli_ex_pkg::slice_t  o_alu_slice,
  output var idli_ex_pkg::flags_t  o_alu_flags
);

  // Subtract mode and the possibly inverted right operand.
  logic                sub;
  idli_ex_pkg::slice_t rhs_eff;

  // Adder with its carry-out in the top bit.
  logic                               cin;
  logic [idli_ex_pkg::SLICE_W:0]      sum;

  // Carry and running zero flag from the previous slice.
  logic carry_q;
  logic z_q;
  logic z_prev;

  // Compares are decoded as SUB, so this covers them too.
  always_comb sub = i_alu_ctrl.alu_op == idli_ex_pkg::ALU_SUB;
  always_comb rhs_eff = sub ? ~i_alu_rhs : i_alu_rhs;

  // Two's complement subtract needs a carry-in of 1 on the first slice.
  always_comb cin = (i_alu_ctr == '0) ? sub : carry_q;

  always_comb sum = {1'b0, i_alu_lhs} + {1'b0, rhs_eff}
                  + {{idli_ex_pkg::SLICE_W{1'b0}}, cin};

  always_comb begin
    unique case (i_alu_ctrl.alu_op)
      idli_ex_pkg::ALU_AND: o_alu_slice = i_alu_lhs & i_alu_rhs;
      idli_ex_pkg::ALU_OR:  o_alu_slice = i_alu_lhs | i_alu_rhs;
      idli_ex_pkg::ALU_XOR: o_alu_slice = i_alu_lhs ^ i_alu_rhs;
      default:              o_alu_slice = sum[idli_ex_pkg::SLICE_W-1:0];
    endcase
  end

  // Zero starts fresh on slice 0 and is ANDed across the word.
  always_comb z_prev = (i_alu_ctr == '0) ? 1'b1 : z_q;

  // n, c and v are only meaningful when taken on slice 3.
  always_comb begin
    o_alu_flags.z = z_prev && (o_alu_slice == '0);
    o_alu_flags.n = sum[idli_ex_pkg::SLICE_W-1];
    o_alu_flags.c = sum[idli_ex_pkg::SLICE_W];
    // Overflow when both inputs agree in sign and the result does not.
    o_alu_flags.v = (i_alu_lhs[idli_ex_pkg::SLICE_W-1] == rhs_eff[idli_ex_pkg::SLICE_W-1])
                 && (sum[idli_ex_pkg::SLICE_W-1] != i_alu_lhs[idli_ex_pkg::SLICE_W-1]);
  end

  always_ff @(posedge i_alu_gck) begin
    if (i_alu_busy) begin
      carry_q <= sum[idli_ex_pkg::SLICE_W];
      z_q     <= o_alu_flags.z;
    end
  end

  // The carry chain is only correct if the operation holds for all slices.
  a_ctrl_stable: assert property (@(posedge i_alu_gck)
    i_alu_busy |=> !i_alu_busy || $stable(i_alu_ctrl));

endmodule

`default_nettype wire

// File: src/idli_ex_rf.sv
`timescale 1ns/1ps
`default_nettype none

// Register file. Reads are one slice per cycle, writes take the whole word.
module idli_ex_rf (
  input  var logic                 i_rf_gck,

  input  var idli_ex_pkg::ctr_t    i_rf_ctr,
  input  var idli_ex_pkg::reg_t    i_rf_lhs,
  input  var idli_ex_pkg::reg_t    i_rf_rhs,

  input  var logic                 i_rf_wr_en,
  input  var idli_ex_pkg::reg_t    i_rf_wr_reg,
  input  var idli_ex_pkg::word_t   i_rf_wr_data,

  output var idli_ex_pkg::slice_t  o_rf_lhs_slice,
  output var logic                 o_rf_lhs_next,
  output var logic                 o_rf_lhs_prev,
  output var idli_ex_pkg::slice_t  o_rf_rhs_slice
);

  idli_ex_pkg::word_t regs_q [idli_ex_pkg::NUM_REGS];

  // Whole operand words as slices, with R0 forced to zero.
  idli_ex_pkg::slice_t [idli_ex_pkg::NUM_SLICES-1:0] lhs_word;
  idli_ex_pkg::slice_t [idli_ex_pkg::NUM_SLICES-1:0] rhs_word;

  // Neighbouring slice positions. These wrap, so slice 0 sees slice 3 as
  // its previous neighbour.
  idli_ex_pkg::ctr_t ctr_next;
  idli_ex_pkg::ctr_t ctr_prev;

  // R0 is never written so it cannot be corrupted.
  always_ff @(posedge i_rf_gck) begin
    if (i_rf_wr_en && i_rf_wr_reg != '0) begin
      regs_q[i_rf_wr_reg] <= i_rf_wr_data;
    end
  end

  always_comb lhs_word = (i_rf_lhs == '0) ? '0 : regs_q[i_rf_lhs];
  always_comb rhs_word = (i_rf_rhs == '0) ? '0 : regs_q[i_rf_rhs];

  always_comb ctr_next = i_rf_ctr + 1'b1;
  always_comb ctr_prev = i_rf_ctr - 1'b1;

  always_comb o_rf_lhs_slice = lhs_word[i_rf_ctr];
  always_comb o_rf_rhs_slice = rhs_word[i_rf_ctr];

  // Nothing lies above slice 3, so the next bit is zero there.
  always_comb o_rf_lhs_next = (&i_rf_ctr) ? 1'b0 : lhs_word[ctr_next][0];

  // At slice 0 the wrap gives bit 15, which is what ROL needs.
  always_comb o_rf_lhs_prev = lhs_word[ctr_prev][idli_ex_pkg::SLICE_W-1];

endmodule

`default_nettype wire

// File: src/idli_ex_seq.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction sequencer. Captures the instruction, steps through the four
// slices and decodes the op field for the unit that runs it.
module idli_ex_seq (
  input  var logic                 i_seq_gck,
  input  var logic                 i_seq_rst_n,

  input  var idli_ex_pkg::instr_t  i_seq_instr,
  input  var logic                 i_seq_instr_vld,
  input  var idli_ex_pkg::slice_t  i_seq_rhs_reg_slice,

  output var idli_ex_pkg::ctrl_t   o_seq_ctrl,
  output var idli_ex_pkg::ctr_t    o_seq_ctr,
  output var logic                 o_seq_busy,
  output var idli_ex_pkg::reg_t    o_seq_lhs,
  output var idli_ex_pkg::reg_t    o_seq_rhs,
  output var idli_ex_pkg::slice_t  o_seq_rhs_slice
);

  // Captured instruction, kept until the next strobe.
  idli_ex_pkg::instr_t instr_q;

  // Slice position and running state.
  idli_ex_pkg::ctr_t   ctr_q;
  logic                busy_q;

  // The immediate viewed as its four slices.
  idli_ex_pkg::slice_t [idli_ex_pkg::NUM_SLICES-1:0] imm_slices;

  always_ff @(posedge i_seq_gck) begin
    if (i_seq_instr_vld) begin
      instr_q <= i_seq_instr;
    end
  end

  // The counter starts at slice 0 on the strobe and wraps back to 0 after
  // slice 3, which is also where busy drops.
  always_ff @(posedge i_seq_gck, negedge i_seq_rst_n) begin
    if (!i_seq_rst_n) begin
      busy_q <= 1'b0;
      ctr_q  <= '0;
    end else if (i_seq_instr_vld) begin
      busy_q <= 1'b1;
      ctr_q  <= '0;
    end else if (busy_q) begin
      busy_q <= ~&ctr_q;
      ctr_q  <= ctr_q + 1'b1;
    end
  end

  // Decode the op field. Compares run through the ALU as a subtract, and
  // shifts leave the ALU on a harmless add.
  always_comb begin
    o_seq_ctrl.unit     = instr_q.unit;
    o_seq_ctrl.cond     = instr_q.cond;
    o_seq_ctrl.dst      = instr_q.dst;
    o_seq_ctrl.shift_op = idli_ex_pkg::shift_op_t'(instr_q.op[1:0]);
    o_seq_ctrl.cmp_op   = idli_ex_pkg::cmp_op_t'(instr_q.op);
    unique case (instr_q.unit)
      idli_ex_pkg::UNIT_ALU: o_seq_ctrl.alu_op = idli_ex_pkg::alu_op_t'(instr_q.op);
      idli_ex_pkg::UNIT_CMP: o_seq_ctrl.alu_op = idli_ex_pkg::ALU_SUB;
      default:               o_seq_ctrl.alu_op = idli_ex_pkg::ALU_ADD;
    endcase
  end

  // Right operand comes from the register file or the matching slice of the
  // immediate.
  always_comb imm_slices = instr_q.imm;
  always_comb o_seq_rhs_slice = instr_q.rhs_imm ? imm_slices[ctr_q] : i_seq_rhs_reg_slice;

  always_comb o_seq_lhs  = instr_q.lhs;
  always_comb o_seq_rhs  = instr_q.rhs;
  always_comb o_seq_ctr  = ctr_q;
  always_comb o_seq_busy = busy_q;

  // Strobes must be spaced so that each instruction finishes before the next.
  a_strobe_gap: assert property (@(posedge i_seq_gck) disable iff (!i_seq_rst_n)
    i_seq_instr_vld |=> !i_seq_instr_vld [* idli_ex_pkg::MIN_GAP-1]);

  a_no_strobe_busy: assert property (@(posedge i_seq_gck) disable iff (!i_seq_rst_n)
    i_seq_instr_vld |-> !busy_q);

  // Every instruction starts on slice 0.
  a_busy_rise_ctr: assert property (@(posedge i_seq_gck) disable iff (!i_seq_rst_n)
    $rose(busy_q) |-> ctr_q == '0);

endmodule

`default_nettype wire

// File: src/idli_ex_pkg.sv
`default_nettype none

// Shared widths, types and encodings for the nibble-serial execution core.
package idli_ex_pkg;

  // A 16-bit word is processed as four 4-bit slices, lowest slice first.
  localparam int WORD_W     = 16;
  localparam int SLICE_W    = 4;
  localparam int NUM_SLICES = WORD_W / SLICE_W;
  localparam int NUM_REGS   = 8;

  // Fewest cycles from one instruction strobe to the next.
  localparam int MIN_GAP    = 5;

  typedef logic [WORD_W-1:0]             word_t;
  typedef logic [SLICE_W-1:0]            slice_t;
  typedef logic [$clog2(NUM_REGS)-1:0]   reg_t;
  typedef logic [$clog2(NUM_SLICES)-1:0] ctr_t;

  // Execution unit that produces the result of an instruction.
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_SHIFT = 2'd1,
    UNIT_CMP   = 2'd2
  } unit_t;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_t;

  typedef enum logic [1:0] {
    SHIFT_SHL = 2'd0,
    SHIFT_SRL = 2'd1,
    SHIFT_SRA = 2'd2,
    SHIFT_ROL = 2'd3
  } shift_op_t;

  typedef enum logic [2:0] {
    CMP_EQ  = 3'd0,
    CMP_NE  = 3'd1,
    CMP_LT  = 3'd2,
    CMP_LTU = 3'd3,
    CMP_GE  = 3'd4,
    CMP_GEU = 3'd5
  } cmp_op_t;

  // Predication mode, checked against P on the last slice.
  typedef enum logic [1:0] {
    COND_ALWAYS   = 2'd0,
    COND_IF_P     = 2'd1,
    COND_IF_NOT_P = 2'd2
  } cond_t;

  // Instruction as presented on the strobe. The op field is read according to unit.
  typedef struct packed {
    unit_t      unit;
    logic [2:0] op;
    cond_t      cond;
    reg_t       dst;
    reg_t       lhs;
    reg_t       rhs;
    logic       rhs_imm;
    word_t      imm;
  } instr_t;

  // Decoded controls, held steady while the instruction runs.
  typedef struct packed {
    unit_t     unit;
    alu_op_t   alu_op;
    shift_op_t shift_op;
    cmp_op_t   cmp_op;
    cond_t     cond;
    reg_t      dst;
  } ctrl_t;

  typedef struct packed {
    logic z;
    logic n;
    logic c;
    logic v;
  } flags_t;

endpackage

`default_nettype wire
